/* flist.f */
+incdir+verilog
+incdir+sim
verilog/ethTypesPkg.sv
verilog/ipTypesPkg.sv
verilog/frameL2Rx.sv
verilog/frameL3Rx.sv
verilog/frameL4Rx.sv
verilog/udpRxStack.sv
sim/udpRxStackTb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = udpRxStackTb
FLIST     = flist.f
OBJDIR    = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* sim/udpRxFrameBuilder.svh */
`ifndef UDP_RX_FRAME_BUILDER_SVH
`define UDP_RX_FRAME_BUILDER_SVH

// Bit-serial IEEE 802.3 CRC-32, data LSB first
function automatic logic [31:0] crc32Next(input logic [31:0] crc, input logic [7:0] data);
    logic [31:0] c;
    logic feedback;
    c = crc;
    for (int b = 0; b < 8; b++)
    begin
        feedback = c[0] ^ data[b];
        c = c >> 1;
        if (feedback)
            c = c ^ 32'hedb8_8320;
    end
    return c;
endfunction

// Network byte order, most significant byte first
task automatic appendBytes(inout logic [7:0] bytes[$], input logic [63:0] value, input int count);
    for (int i = count - 1; i >= 0; i--)
        bytes.push_back(value[8*i +: 8]);
endtask

// Ethernet, IPv4 and UDP headers around a payload, then the FCS
// A flipBit of 0 to 31 corrupts that bit of the FCS
task automatic buildFrame(
    input  logic [47:0] dstMac,
    input  logic [47:0] srcMac,
    input  logic [15:0] etherType,
    input  logic [7:0]  verIhl,
    input  logic [7:0]  proto,
    input  logic [31:0] srcIp,
    input  logic [31:0] dstIp,
    input  logic [15:0] srcPort,
    input  logic [15:0] dstPort,
    input  logic [7:0]  payload[$],
    input  int          flipBit,
    output logic [7:0]  frame[$]
);
    logic [31:0] crc;
    logic [31:0] fcs;
    frame = {};
    appendBytes(frame, dstMac, 6);
    appendBytes(frame, srcMac, 6);
    appendBytes(frame, etherType, 2);
    // IPv4 header with DF set, checksum left at zero
    appendBytes(frame, verIhl, 1);
    appendBytes(frame, 8'h00, 1);
    appendBytes(frame, 64'(`IP_HEADER_LEN + `UDP_HEADER_LEN + payload.size()), 2);
    appendBytes(frame, 32'h0000_4000, 4);
    appendBytes(frame, 8'd64, 1);
    appendBytes(frame, proto, 1);
    appendBytes(frame, 16'h0000, 2);
    appendBytes(frame, srcIp, 4);
    appendBytes(frame, dstIp, 4);
    // UDP header without checksum
    appendBytes(frame, srcPort, 2);
    appendBytes(frame, dstPort, 2);
    appendBytes(frame, 64'(`UDP_HEADER_LEN + payload.size()), 2);
    appendBytes(frame, 16'h0000, 2);
    foreach (payload[i])
        frame.push_back(payload[i]);
    crc = 32'hffff_ffff;
    foreach (frame[i])
        crc = crc32Next(crc, frame[i]);
    fcs = ~crc;
    if (flipBit >= 0)
        fcs[flipBit] = ~fcs[flipBit];
    // FCS goes out least significant byte first
    for (int i = 0; i < `FCS_LEN; i++)
        frame.push_back(fcs[8*i +: 8]);
endtask

`endif

/* sim/udpRxStackTb.sv */
`timescale 1ns/1ps
`include "gmacRx_config.svh"

module udpRxStackTb;
    import ethTypesPkg::*;
    import ipTypesPkg::*;

    localparam int ResetCycles = 8;
    localparam int SingleFrames = 10;
    localparam int BurstFrames = 12;
    localparam int WatchdogCycles = (SingleFrames + BurstFrames) * 2000;
    localparam int DrainLimit = 400;
    localparam int SettleCycles = 12;
    localparam logic [47:0] LocalMac = 48'h02_00_5e_10_20_30;
    localparam logic [31:0] LocalIp = 32'hc0a8_0164;
    localparam logic [15:0] LocalPort = 16'd5000;
    localparam logic [47:0] SenderMac = 48'h02_11_22_33_44_55;
    localparam logic [31:0] SenderIp = 32'hc0a8_0101;

    typedef struct packed
    {
        logic [7:0] data;
        logic       sof;
        logic       eof;
        logic       err;
    } expByteT;

    typedef struct packed
    {
        logic [47:0] mac;
        logic [31:0] ip;
        logic [15:0] port;
    } senderT;

    logic clk125;
    logic reset;
    logic rxValid;
    logic rxSof;
    logic rxEof;
    logic [7:0] rxData;
    logic [47:0] localMac;
    logic [31:0] localIp;
    logic [15:0] localPort;
    logic outValid;
    logic outSof;
    logic outEof;
    logic outErr;
    logic [7:0] outData;
    logic [47:0] remoteMac;
    logic [31:0] remoteIp;
    logic [15:0] remotePort;
    logic [`ERR_COUNT_WIDTH-1:0] fcsErrorCount;

    integer seed = 32'hdeacf8c9;
    expByteT expBytes[$];
    senderT expSenders[$];
    logic [`ERR_COUNT_WIDTH-1:0] modelErrCount = '0;
    logic started = 1'b0;
    logic countCheck = 1'b0;
    logic anyFailure = 1'b0;

    // Snapshot of the outputs taken on the falling edge
    expByteT expByte = '0;
    expByteT seenByte = '0;
    senderT expSender = '0;
    senderT seenSender = '0;
    logic byteCheck = 1'b0;
    logic senderCheck = 1'b0;
    logic unexpectedOut = 1'b0;

    udpRxStack dut_i
    (
        .clk125        (clk125),
        .reset         (reset),
        .rxValid       (rxValid),
        .rxSof         (rxSof),
        .rxEof         (rxEof),
        .rxData        (rxData),
        .localMac      (localMac),
        .localIp       (localIp),
        .localPort     (localPort),
        .outValid      (outValid),
        .outSof        (outSof),
        .outEof        (outEof),
        .outErr        (outErr),
        .outData       (outData),
        .remoteMac     (remoteMac),
        .remoteIp      (remoteIp),
        .remotePort    (remotePort),
        .fcsErrorCount (fcsErrorCount)
    );

    `include "udpRxFrameBuilder.svh"

    initial
        clk125 = 1'b0;

    always #4 clk125 = ~clk125;

    task automatic stopOnFailure();
        anyFailure = 1'b1;
        $display("SOME TESTS FAILED");
        $fatal(1, "Stopping after the first failed check");
    endtask

    task automatic reportMismatch(input string name, input logic [63:0] got,
                                  input logic [63:0] expected);
        $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, expected);
        stopOnFailure();
    endtask

    task automatic reportProblem(input string reason);
        $display("Failure: %s", reason);
        stopOnFailure();
    endtask

    // Gaps only between the bytes of a frame and never before its first byte
    task automatic driveFrame(input logic [7:0] frame[$], input bit gaps);
        for (int i = 0; i < frame.size(); i++)
        begin
            if (gaps && i != 0)
            begin
                while (($unsigned($random(seed)) % 4) == 0)
                begin
                    rxValid <= 1'b0;
                    rxSof <= 1'b0;
                    rxEof <= 1'b0;
                    @(posedge clk125);
                end
            end
            rxValid <= 1'b1;
            rxSof <= (i == 0);
            rxEof <= (i == frame.size() - 1);
            rxData <= frame[i];
            @(posedge clk125);
        end
    endtask

    // Kinds 0 and 1 pass, 2 to 7 are filtered, 8 and 9 carry a bad FCS
    task automatic sendKind(input int kind, input bit gaps);
        logic [7:0] payload[$];
        logic [7:0] frame[$];
        logic [47:0] dstMac;
        logic [47:0] srcMac;
        logic [15:0] etherType;
        logic [7:0] verIhl;
        logic [7:0] proto;
        logic [31:0] srcIp;
        logic [31:0] dstIp;
        logic [15:0] dstPort;
        logic [15:0] srcPort;
        int payloadLen;
        int flipBit;
        bit accepted;
        expByteT entry;
        payloadLen = 18 + int'($unsigned($random(seed)) % 47);
        for (int i = 0; i < payloadLen; i++)
            payload.push_back(8'($random(seed)));
        srcPort = 16'($random(seed));
        // Sender address differs from frame to frame
        srcMac = {SenderMac[47:16], 16'($random(seed))};
        srcIp = {SenderIp[31:8], 8'($random(seed))};
        dstMac = LocalMac;
        etherType = etherTypeIpv4;
        verIhl = 8'h45;
        proto = protoUdp;
        dstIp = LocalIp;
        dstPort = LocalPort;
        flipBit = -1;
        case (kind)
            1: dstMac = 48'hffff_ffff_ffff;
            2: dstMac = LocalMac ^ 48'h1;
            3: etherType = etherTypeArp;
            4: verIhl = 8'h46;
            5: dstIp = LocalIp ^ 32'h100;
            6: proto = protoTcp;
            7: dstPort = 16'(LocalPort + 1);
            8: flipBit = int'($unsigned($random(seed)) % 32);
            9:
            begin
                dstMac = 48'h02_99_88_77_66_55;
                flipBit = int'($unsigned($random(seed)) % 32);
            end
            default: dstMac = LocalMac;
        endcase
        accepted = (kind <= 1) || (kind == 8);
        if (flipBit >= 0)
            modelErrCount = modelErrCount + 1'b1;
        buildFrame(dstMac, srcMac, etherType, verIhl, proto, srcIp, dstIp,
                   srcPort, dstPort, payload, flipBit, frame);
        if (accepted)
        begin
            foreach (payload[i])
            begin
                entry.data = payload[i];
                entry.sof = (i == 0);
                entry.eof = (i == payloadLen - 1);
                entry.err = entry.eof && (flipBit >= 0);
                expBytes.push_back(entry);
            end
            expSenders.push_back({srcMac, srcIp, srcPort});
        end
        driveFrame(frame, gaps);
    endtask

    // Idle the input, wait for the expected payload, then check the counter
    task automatic finishBurst();
        int waited;
        waited = 0;
        rxValid <= 1'b0;
        rxSof <= 1'b0;
        rxEof <= 1'b0;
        @(posedge clk125);
        while (expBytes.size() != 0 && waited < DrainLimit)
        begin
            @(posedge clk125);
            waited++;
        end
        if (expBytes.size() != 0)
            reportProblem("expected payload bytes were not delivered in time");
        repeat (SettleCycles) @(posedge clk125);
        countCheck <= 1'b1;
        @(posedge clk125);
        countCheck <= 1'b0;
    endtask

    always @(negedge clk125)
    begin
        byteCheck = 1'b0;
        senderCheck = 1'b0;
        unexpectedOut = 1'b0;
        if (!reset && outValid)
        begin
            if (expBytes.size() == 0 || (outSof && expSenders.size() == 0))
                unexpectedOut = 1'b1;
            else
            begin
                expByte = expBytes.pop_front();
                seenByte = {outData, outSof, outEof, outErr};
                byteCheck = 1'b1;
                if (outSof)
                begin
                    expSender = expSenders.pop_front();
                    seenSender = {remoteMac, remoteIp, remotePort};
                    senderCheck = 1'b1;
                end
            end
        end
    end

    // Quiet outputs until the first frame goes in
    assert property (@(posedge clk125) disable iff (reset)
        !started |-> ({outValid, outSof, outEof, outErr} == 4'b0))
        else reportMismatch("out strobes", $sampled({outValid, outSof, outEof, outErr}), 4'b0);

    assert property (@(posedge clk125) disable iff (reset)
        !started |-> (fcsErrorCount == '0))
        else reportMismatch("fcsErrorCount", $sampled(fcsErrorCount), 0);

    assert property (@(posedge clk125) disable iff (reset) !unexpectedOut)
        else reportProblem("outValid or outSof seen with no expected datagram pending");

    assert property (@(posedge clk125) disable iff (reset)
        byteCheck |-> (seenByte.data == expByte.data))
        else reportMismatch("outData", seenByte.data, expByte.data);

    assert property (@(posedge clk125) disable iff (reset)
        byteCheck |-> (seenByte.sof == expByte.sof))
        else reportMismatch("outSof", seenByte.sof, expByte.sof);

    assert property (@(posedge clk125) disable iff (reset)
        byteCheck |-> (seenByte.eof == expByte.eof))
        else reportMismatch("outEof", seenByte.eof, expByte.eof);

    assert property (@(posedge clk125) disable iff (reset)
        byteCheck |-> (seenByte.err == expByte.err))
        else reportMismatch("outErr", seenByte.err, expByte.err);

    // Sender fields at the first payload byte
    assert property (@(posedge clk125) disable iff (reset)
        senderCheck |-> (seenSender.mac == expSender.mac))
        else reportMismatch("remoteMac", seenSender.mac, expSender.mac);

    assert property (@(posedge clk125) disable iff (reset)
        senderCheck |-> (seenSender.ip == expSender.ip))
        else reportMismatch("remoteIp", seenSender.ip, expSender.ip);

    assert property (@(posedge clk125) disable iff (reset)
        senderCheck |-> (seenSender.port == expSender.port))
        else reportMismatch("remotePort", seenSender.port, expSender.port);

    assert property (@(posedge clk125) disable iff (reset)
        countCheck |-> (fcsErrorCount == modelErrCount))
        else reportMismatch("fcsErrorCount", $sampled(fcsErrorCount), modelErrCount);

    initial
    begin
        repeat (WatchdogCycles) @(posedge clk125);
        reportProblem("watchdog expired before the test sequence completed");
    end

    initial
    begin
        int kind;
        reset = 1'b1;
        rxValid = 1'b0;
        rxSof = 1'b0;
        rxEof = 1'b0;
        rxData = 8'h00;
        localMac = LocalMac;
        localIp = LocalIp;
        localPort = LocalPort;
        repeat (ResetCycles) @(posedge clk125);
        reset <= 1'b0;
        // A stretch of idle cycles after reset
        repeat (10) @(posedge clk125);
        started <= 1'b1;
        for (int k = 0; k < SingleFrames; k++)
        begin
            sendKind(k, 1'b0);
            finishBurst();
        end
        // Back to back with every other frame one that passes
        for (int n = 0; n < BurstFrames; n++)
        begin
            if (n % 2 == 0)
                kind = int'($unsigned($random(seed)) % 2);
            else
                kind = int'($unsigned($random(seed)) % 10);
            sendKind(kind, 1'b1);
        end
        finishBurst();
        if (!anyFailure)
        begin
            $display("ALL TESTS PASSED");
            $finish;
        end
        else
        begin
            stopOnFailure();
        end
    end

endmodule

/* verilog/udpRxStack.sv */
`timescale 1ns/1ps
`include "gmacRx_config.svh"

module udpRxStack
(
    input  logic                        clk125,
    input  logic                        reset,
    input  logic                        rxValid,
    input  logic                        rxSof,
    input  logic                        rxEof,
    input  logic [7:0]                  rxData,
    input  logic [47:0]                 localMac,
    input  logic [31:0]                 localIp,
    input  logic [15:0]                 localPort,
    output logic                        outValid,
    output logic                        outSof,
    output logic                        outEof,
    output logic                        outErr,
    output logic [7:0]                  outData,
    output logic [47:0]                 remoteMac,
    output logic [31:0]                 remoteIp,
    output logic [15:0]                 remotePort,
    output logic [`ERR_COUNT_WIDTH-1:0] fcsErrorCount
);

    // Ethernet to IPv4
    logic l2Valid;
    logic l2Sof;
    logic l2Eof;
    logic l2Err;
    logic [7:0] l2Data;
    logic [47:0] l2RemoteMac;
    logic fcsError;

    // IPv4 to UDP
    logic l3Valid;
    logic l3Sof;
    logic l3Eof;
    logic l3Err;
    logic [7:0] l3Data;
    logic [47:0] l3RemoteMac;
    logic [31:0] l3RemoteIp;

    frameL2Rx frameL2Rx_i
    (
        .clk125    (clk125),
        .reset     (reset),
        .rxValid   (rxValid),
        .rxSof     (rxSof),
        .rxEof     (rxEof),
        .rxData    (rxData),
        .localMac  (localMac),
        .l2Valid   (l2Valid),
        .l2Sof     (l2Sof),
        .l2Eof     (l2Eof),
        .l2Err     (l2Err),
        .l2Data    (l2Data),
        .remoteMac (l2RemoteMac),
        .fcsError  (fcsError)
    );

    frameL3Rx frameL3Rx_i
    (
        .clk125       (clk125),
        .reset        (reset),
        .l2Valid      (l2Valid),
        .l2Sof        (l2Sof),
        .l2Eof        (l2Eof),
        .l2Err        (l2Err),
        .l2Data       (l2Data),
        .remoteMacIn  (l2RemoteMac),
        .localIp      (localIp),
        .l3Valid      (l3Valid),
        .l3Sof        (l3Sof),
        .l3Eof        (l3Eof),
        .l3Err        (l3Err),
        .l3Data       (l3Data),
        .remoteMacOut (l3RemoteMac),
        .remoteIp     (l3RemoteIp)
    );

    frameL4Rx frameL4Rx_i
    (
        .clk125      (clk125),
        .reset       (reset),
        .l3Valid     (l3Valid),
        .l3Sof       (l3Sof),
        .l3Eof       (l3Eof),
        .l3Err       (l3Err),
        .l3Data      (l3Data),
        .remoteMacIn (l3RemoteMac),
        .remoteIpIn  (l3RemoteIp),
        .localPort   (localPort),
        .outValid    (outValid),
        .outSof      (outSof),
        .outEof      (outEof),
        .outErr      (outErr),
        .outData     (outData),
        .remoteMac   (remoteMac),
        .remoteIp    (remoteIp),
        .remotePort  (remotePort)
    );

    // Counts every bad FCS, also for frames dropped by the filters
    always_ff @(posedge clk125)
    begin
        if (reset)
        begin
            fcsErrorCount <= '0;
        end
        else if (fcsError)
        begin
            fcsErrorCount <= fcsErrorCount + 1'b1;
        end
    end

endmodule

/* verilog/frameL4Rx.sv */
`timescale 1ns/1ps
`include "gmacRx_config.svh"

module frameL4Rx
(
    input  logic        clk125,
    input  logic        reset,
    input  logic        l3Valid,
    input  logic        l3Sof,
    input  logic        l3Eof,
    input  logic        l3Err,
    input  logic [7:0]  l3Data,
    input  logic [47:0] remoteMacIn,
    input  logic [31:0] remoteIpIn,
    input  logic [15:0] localPort,
    output logic        outValid,
    output logic        outSof,
    output logic        outEof,
    output logic        outErr,
    output logic [7:0]  outData,
    output logic [47:0] remoteMac,
    output logic [31:0] remoteIp,
    output logic [15:0] remotePort
);
    import ipTypesPkg::*;

    localparam int CountW = $clog2(`UDP_HEADER_LEN);
    localparam int PortBytes = 4;

    l4StateT state;
    logic [CountW-1:0] hdrCount;
    logic firstOut;
    logic [31:0] portShift;
    logic headerLast;
    logic portWindow;

    assign headerLast = (hdrCount == CountW'(`UDP_HEADER_LEN - 1));
    // Source and destination port occupy the first four bytes
    assign portWindow = l3Sof || (state == l4Header && hdrCount < CountW'(PortBytes));

    always_ff @(posedge clk125)
    begin
        if (reset)
        begin
            state <= l4Drop;
            hdrCount <= '0;
            firstOut <= 1'b0;
            outValid <= 1'b0;
            outSof <= 1'b0;
            outEof <= 1'b0;
            outErr <= 1'b0;
        end
        else
        begin
            outValid <= 1'b0;
            outSof <= 1'b0;
            outEof <= 1'b0;
            outErr <= 1'b0;
            if (l3Valid)
            begin
                if (l3Sof)
                begin
                    hdrCount <= CountW'(1);
                    firstOut <= 1'b1;
                    state <= l3Eof ? l4Drop : l4Header;
                end
                else
                begin
                    case (state)
                        l4Header:
                        begin
                            hdrCount <= hdrCount + 1'b1;
                            if (l3Eof)
                            begin
                                state <= l4Drop;
                            end
                            else if (headerLast)
                            begin
                                state <= (portShift[15:0] == localPort) ? l4Payload : l4Drop;
                            end
                        end
                        l4Payload:
                        begin
                            outValid <= 1'b1;
                            outSof <= firstOut;
                            outEof <= l3Eof;
                            outErr <= l3Err;
                            firstOut <= 1'b0;
                            if (l3Eof)
                            begin
                                state <= l4Drop;
                            end
                        end
                        default:
                        begin
                            state <= l4Drop;
                        end
                    endcase
                end
            end
        end
    end

    always_ff @(posedge clk125)
    begin
        if (l3Valid && portWindow)
        begin
            portShift <= {portShift[23:0], l3Data};
        end
        if (l3Valid)
        begin
            outData <= l3Data;
        end
        // Sender fields change together with outSof
        if (l3Valid && !l3Sof && state == l4Payload && firstOut)
        begin
            remoteMac <= remoteMacIn;
            remoteIp <= remoteIpIn;
            remotePort <= portShift[31:16];
        end
    end

endmodule

/* verilog/frameL3Rx.sv */
`timescale 1ns/1ps
`include "gmacRx_config.svh"

module frameL3Rx
(
    input  logic        clk125,
    input  logic        reset,
    input  logic        l2Valid,
    input  logic        l2Sof,
    input  logic        l2Eof,
    input  logic        l2Err,
    input  logic [7:0]  l2Data,
    input  logic [47:0] remoteMacIn,
    input  logic [31:0] localIp,
    output logic        l3Valid,
    output logic        l3Sof,
    output logic        l3Eof,
    output logic        l3Err,
    output logic [7:0]  l3Data,
    output logic [47:0] remoteMacOut,
    output logic [31:0] remoteIp
);
    import ipTypesPkg::*;

    localparam int CountW = $clog2(`IP_HEADER_LEN);
    localparam int ProtoIndex = 9;
    // Version 4 with the only supported IHL
    localparam logic [7:0] VersionIhl = {4'd4, 4'(`IP_HEADER_LEN / 4)};

    l3StateT state;
    logic [CountW-1:0] hdrCount;
    logic protoOk;
    logic firstOut;
    logic [55:0] ipShift;
    logic headerLast;
    logic ipMatch;
    logic accept;

    assign headerLast = (hdrCount == CountW'(`IP_HEADER_LEN - 1));
    // Destination address ends on the last header byte
    assign ipMatch = ({ipShift[23:0], l2Data} == localIp);
    assign accept = l2Valid && !l2Sof && !l2Eof && (state == l3Header) && headerLast
                 && protoOk && ipMatch;

    always_ff @(posedge clk125)
    begin
        if (reset)
        begin
            state <= l3Drop;
            hdrCount <= '0;
            protoOk <= 1'b0;
            firstOut <= 1'b0;
            l3Valid <= 1'b0;
            l3Sof <= 1'b0;
            l3Eof <= 1'b0;
            l3Err <= 1'b0;
        end
        else
        begin
            l3Valid <= 1'b0;
            l3Sof <= 1'b0;
            l3Eof <= 1'b0;
            l3Err <= 1'b0;
            if (l2Valid)
            begin
                if (l2Sof)
                begin
                    hdrCount <= CountW'(1);
                    protoOk <= 1'b1;
                    firstOut <= 1'b1;
                    state <= (l2Data == VersionIhl && !l2Eof) ? l3Header : l3Drop;
                end
                else
                begin
                    case (state)
                        l3Header:
                        begin
                            hdrCount <= hdrCount + 1'b1;
                            if (hdrCount == CountW'(ProtoIndex) && l2Data != protoUdp)
                            begin
                                protoOk <= 1'b0;
                            end
                            if (l2Eof || headerLast)
                            begin
                                state <= accept ? l3Payload : l3Drop;
                            end
                        end
                        l3Payload:
                        begin
                            l3Valid <= 1'b1;
                            l3Sof <= firstOut;
                            l3Eof <= l2Eof;
                            l3Err <= l2Err;
                            firstOut <= 1'b0;
                            if (l2Eof)
                            begin
                                state <= l3Drop;
                            end
                        end
                        default:
                        begin
                            state <= l3Drop;
                        end
                    endcase
                end
            end
        end
    end

    always_ff @(posedge clk125)
    begin
        if (l2Valid)
        begin
            ipShift <= {ipShift[47:0], l2Data};
            l3Data <= l2Data;
        end
        // Source address is bytes 12 to 15, now at the top of the shifter
        if (accept)
        begin
            remoteIp <= ipShift[55:24];
            remoteMacOut <= remoteMacIn;
        end
    end

endmodule

/* verilog/frameL2Rx.sv */
`timescale 1ns/1ps
`include "gmacRx_config.svh"

module frameL2Rx
(
    input  logic        clk125,
    input  logic        reset,
    input  logic        rxValid,
    input  logic        rxSof,
    input  logic        rxEof,
    input  logic [7:0]  rxData,
    input  logic [47:0] localMac,
    output logic        l2Valid,
    output logic        l2Sof,
    output logic        l2Eof,
    output logic        l2Err,
    output logic [7:0]  l2Data,
    output logic [47:0] remoteMac,
    output logic        fcsError
);
    import ethTypesPkg::*;

    localparam int HdrW = $clog2(`ETH_HEADER_LEN);
    localparam int HoldW = $clog2(`FCS_LEN + 1);
    localparam int ShiftW = (`ETH_HEADER_LEN - 1) * 8;
    localparam logic [31:0] CrcInit = 32'hffff_ffff;
    localparam logic [31:0] CrcResidue = 32'hdebb_20e3;
    localparam logic [47:0] BroadcastMac = 48'hffff_ffff_ffff;

    l2StateT state;
    etherTypeT etherType;
    logic [HdrW-1:0] hdrCount;
    logic [ShiftW-1:0] headerShift;
    logic [HoldW-1:0] holdCount;
    logic [7:0] holdLine [`FCS_LEN];
    logic firstOut;
    logic [31:0] crcReg;
    logic [31:0] crcNow;
    logic fcsBad;
    logic macMatch;
    logic headerLast;
    logic holdFull;
    logic accept;

    // Reflected CRC-32, one byte per call
    function automatic logic [31:0] crcByte(input logic [31:0] crc, input logic [7:0] data);
        logic [31:0] c;
        c = crc ^ {24'h0, data};
        for (int i = 0; i < 8; i++)
        begin
            c = c[0] ? ((c >> 1) ^ 32'hedb8_8320) : (c >> 1);
        end
        return c;
    endfunction

    always_comb
    begin
        crcNow = crcByte(rxSof ? CrcInit : crcReg, rxData);
        fcsBad = (crcNow != CrcResidue);
        // Last header byte is still on rxData, the rest sits in the shift register
        etherType = etherTypeT'({headerShift[7:0], rxData});
        macMatch = (headerShift[ShiftW-1 -: 48] == localMac)
                || (headerShift[ShiftW-1 -: 48] == BroadcastMac);
        headerLast = (hdrCount == HdrW'(`ETH_HEADER_LEN - 1));
        holdFull = (holdCount == HoldW'(`FCS_LEN));
        accept = rxValid && !rxSof && !rxEof && (state == l2Header) && headerLast
              && macMatch && (etherType == etherTypeIpv4);
    end

    always_ff @(posedge clk125)
    begin
        if (reset)
        begin
            state <= l2Idle;
            hdrCount <= '0;
            holdCount <= '0;
            firstOut <= 1'b0;
            l2Valid <= 1'b0;
            l2Sof <= 1'b0;
            l2Eof <= 1'b0;
            l2Err <= 1'b0;
            fcsError <= 1'b0;
        end
        else
        begin
            l2Valid <= 1'b0;
            l2Sof <= 1'b0;
            l2Eof <= 1'b0;
            l2Err <= 1'b0;
            fcsError <= 1'b0;
            if (rxValid)
            begin
                if (rxSof)
                begin
                    // A sof restarts the parser from any state
                    hdrCount <= HdrW'(1);
                    state <= rxEof ? l2Idle : l2Header;
                    fcsError <= rxEof;
                end
                else
                begin
                    case (state)
                        l2Header:
                        begin
                            hdrCount <= hdrCount + 1'b1;
                            if (rxEof)
                            begin
                                // Runt frame, reported as an error
                                state <= l2Idle;
                                fcsError <= 1'b1;
                            end
                            else if (headerLast)
                            begin
                                holdCount <= '0;
                                firstOut <= 1'b1;
                                state <= accept ? l2Payload : l2Drop;
                            end
                        end
                        l2Payload:
                        begin
                            if (holdFull)
                            begin
                                l2Valid <= 1'b1;
                                l2Sof <= firstOut;
                                l2Eof <= rxEof;
                                l2Err <= rxEof && fcsBad;
                                firstOut <= 1'b0;
                            end
                            else
                            begin
                                holdCount <= holdCount + 1'b1;
                            end
                            if (rxEof)
                            begin
                                state <= l2Idle;
                                fcsError <= fcsBad;
                            end
                        end
                        l2Drop:
                        begin
                            if (rxEof)
                            begin
                                state <= l2Idle;
                                fcsError <= fcsBad;
                            end
                        end
                        default:
                        begin
                            state <= l2Idle;
                        end
                    endcase
                end
            end
        end
    end

    // Byte shifters and FCS hold line
    always_ff @(posedge clk125)
    begin
        if (rxValid)
        begin
            crcReg <= crcNow;
            headerShift <= {headerShift[ShiftW-9:0], rxData};
            holdLine[0] <= rxData;
            for (int i = 1; i < `FCS_LEN; i++)
            begin
                holdLine[i] <= holdLine[i-1];
            end
            l2Data <= holdLine[`FCS_LEN-1];
        end
        if (accept)
        begin
            remoteMac <= headerShift[ShiftW-49 -: 48];
        end
    end

endmodule

/* verilog/ipTypesPkg.sv */
package ipTypesPkg;

    // IPv4 protocol field
    typedef enum logic [7:0]
    {
        protoTcp = 8'd6,
        protoUdp = 8'd17
    } ipProtoT;

    // IPv4 receive FSM, drop doubles as the wait for the next sof
    typedef enum logic [1:0]
    {
        l3Header,
        l3Payload,
        l3Drop
    } l3StateT;

    // UDP receive FSM
    typedef enum logic [1:0]
    {
        l4Header,
        l4Payload,
        l4Drop
    } l4StateT;

endpackage

/* verilog/ethTypesPkg.sv */
package ethTypesPkg;

    // EtherType values seen in the Ethernet header
    typedef enum logic [15:0]
    {
        etherTypeIpv4 = 16'h0800,
        etherTypeArp  = 16'h0806
    } etherTypeT;

    // L2 receive FSM
    typedef enum logic [1:0]
    {
        l2Idle,
        l2Header,
        l2Payload,
        l2Drop
    } l2StateT;

endpackage

/* verilog/gmacRx_config.svh */
`ifndef GMACRX_CONFIG_SVH
`define GMACRX_CONFIG_SVH

// Header sizes on the receive path, in bytes
`define ETH_HEADER_LEN 14
`define IP_HEADER_LEN 20
`define UDP_HEADER_LEN 8

// Trailing Ethernet FCS held back before forwarding
`define FCS_LEN 4

// Width of the bad FCS counter
`define ERR_COUNT_WIDTH 32

`endif
